//--- src.f
src/mem_pkg.sv
src/data_ram.sv
src/mem_arbiter.sv
src/wb_queue.sv
src/operand_loader.sv
src/opswap.sv
src/mem_stage.sv
verif/mem_checker.sv
verif/tb_mem_stage.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_mem_stage
FILELIST  = src.f
PASS_MSG  = All tests passed!

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qF "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- verif/tb_mem_stage.sv
module tb_mem_stage;

    import mem_pkg::*;

    // 150 random instructions at about 9 cycles each, plus prefill and directed tests, doubled.
    localparam int MAX_CYCLES  = 4000;
    localparam int RAND_INSTRS = 150;

    logic                clk;
    logic                rst_n;
    logic                valid_in;
    logic                fwd_stall;
    logic                mem1_rd;
    logic                mem2_rd;
    logic [ADDR_W-1:0]   mem_addr1;
    logic [ADDR_W-1:0]   mem_addr2;
    logic [OPSIZE_W-1:0] opsize_in;
    logic [DATA_W-1:0]   reg1, reg2, reg3, reg4;
    logic [SEG_W-1:0]    seg1, seg2, seg3, seg4;
    logic [DATA_W-1:0]   imm;
    logic [ADDR_W-1:0]   eip_in;
    logic [SEL_W-1:0]    op1_sel, op2_sel, op3_sel, op4_sel;
    logic                wb_valid;
    logic [ADDR_W-1:0]   wb_memaddr;
    logic [DATA_W-1:0]   wb_memdata;
    logic                wbaq_isfull;
    logic                stall;
    logic                valid_out;
    logic [DATA_W-1:0]   op1_val, op2_val, op3_val, op4_val;
    logic [ADDR_W-1:0]   eip_out;
    logic [OPSIZE_W-1:0] opsize_out;

    logic [DATA_W-1:0]   ref_mem [RAM_DEPTH];
    logic [DATA_W-1:0]   exp_mem1;
    logic [DATA_W-1:0]   exp_mem2;
    logic                exp_push;
    logic                end_check;
    logic [7:0]          test_id;
    logic [31:0]         lcg_state;
    int                  mismatches;
    int                  protocol_errors;
    int                  tb_errors;
    int                  cycles;

    mem_stage mem_stage_inst (.*);

    mem_checker mem_checker_inst (
        .clk(clk), .rst_n(rst_n), .exp_push(exp_push), .end_check(end_check),
        .test_id(test_id),
        .sels({op4_sel, op3_sel, op2_sel, op1_sel}),
        .regs({reg4, reg3, reg2, reg1}),
        .segs({seg4, seg3, seg2, seg1}),
        .imm(imm), .eip_in(eip_in), .opsize_in(opsize_in),
        .mem1_rd(mem1_rd), .mem2_rd(mem2_rd), .mem1_word(exp_mem1), .mem2_word(exp_mem2),
        .valid_out(valid_out),
        .ops({op4_val, op3_val, op2_val, op1_val}),
        .eip_out(eip_out), .opsize_out(opsize_out),
        .mismatches(mismatches), .protocol_errors(protocol_errors)
    );

    always #2 clk = ~clk;

    // Tempered LCG step.
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state ^ (lcg_state >> 15);
    endfunction

    function automatic logic [ADDR_W-1:0] word_addr(input int w);
        return ADDR_W'(w) << WORD_LSB;
    endfunction

    function automatic logic [DATA_W-1:0] fill_word(input int w);
        logic [ADDR_W-1:0] a;
        a = word_addr(w);
        return {a * 32'h9E37_79B9, ~a};
    endfunction

    ////////////////////
    // Drivers.
    ////////////////////

    task automatic push_store(input int w, input logic [DATA_W-1:0] data);
        while (wbaq_isfull) begin
            @(negedge clk);
        end
        wb_valid   = 1'b1;
        wb_memaddr = word_addr(w);
        wb_memdata = data;
        ref_mem[w] = data;
        @(negedge clk);
        wb_valid = 1'b0;
    endtask

    task automatic load_fields(input logic [SEL_W-1:0] s1, input logic [SEL_W-1:0] s2,
                               input logic [SEL_W-1:0] s3, input logic [SEL_W-1:0] s4,
                               input logic rd1, input logic rd2, input int w1, input int w2,
                               input logic [OPSIZE_W-1:0] size);
        op1_sel   = s1;
        op2_sel   = s2;
        op3_sel   = s3;
        op4_sel   = s4;
        mem1_rd   = rd1;
        mem2_rd   = rd2;
        mem_addr1 = word_addr(w1);
        mem_addr2 = word_addr(w2);
        opsize_in = size;
        reg1      = {next_rand(), next_rand()};
        reg2      = {next_rand(), next_rand()};
        reg3      = {next_rand(), next_rand()};
        reg4      = {next_rand(), next_rand()};
        seg1      = SEG_W'(next_rand());
        seg2      = SEG_W'(next_rand());
        seg3      = SEG_W'(next_rand());
        seg4      = SEG_W'(next_rand());
        imm       = {next_rand(), next_rand()};
        eip_in    = next_rand();
    endtask

    // Holds the instruction until the stage drops stall.
    task automatic issue_instr();
        valid_in = 1'b1;
        exp_mem1 = ref_mem[mem_addr1[WORD_LSB +: RAM_AW]];
        exp_mem2 = ref_mem[mem_addr2[WORD_LSB +: RAM_AW]];
        exp_push = 1'b1;
        #1;
        while (stall) begin
            @(negedge clk);
            exp_push = 1'b0;
            #1;
        end
        @(negedge clk);
        exp_push = 1'b0;
        valid_in = 1'b0;
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        logic [31:0] r;
        logic [31:0] q;
        lcg_state  = 32'd23646;
        clk        = 1'b0;
        rst_n      = 1'b0;
        valid_in   = 1'b0;
        fwd_stall  = 1'b0;
        wb_valid   = 1'b0;
        wb_memaddr = '0;
        wb_memdata = '0;
        exp_push   = 1'b0;
        end_check  = 1'b0;
        test_id    = 8'd0;
        tb_errors  = 0;
        cycles     = 0;
        load_fields(SRC_ZERO, SRC_ZERO, SRC_ZERO, SRC_ZERO, 1'b0, 1'b0, 0, 0, OPSIZE_8);
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // Routing only, memory selects without reads give zero.
        test_id = 8'd1;
        load_fields(SRC_REG1, SRC_REG2, SRC_REG3, SRC_REG4, 1'b0, 1'b0, 0, 0, OPSIZE_64);
        issue_instr();
        load_fields(SRC_SEG1, SRC_SEG2, SRC_SEG3, SRC_SEG4, 1'b0, 1'b0, 0, 0, OPSIZE_64);
        issue_instr();
        load_fields(SRC_IMM, SRC_EIP, SRC_ZERO, 4'd13, 1'b0, 1'b0, 0, 0, OPSIZE_32);
        issue_instr();
        load_fields(SRC_MEM1, SRC_MEM2, SRC_EIP, SRC_REG4, 1'b0, 1'b0, 0, 0, OPSIZE_16);
        issue_instr();

        // Prefill, then loads right behind their stores.
        test_id = 8'd2;
        for (int w = 0; w < 128; w++) begin
            push_store(w, fill_word(w));
        end
        for (int s = 0; s < 4; s++) begin
            push_store(8 + 2*s, {next_rand(), next_rand()});
            push_store(9 + 2*s, {next_rand(), next_rand()});
            load_fields(SRC_MEM1, SRC_MEM2, SRC_REG1, SRC_MEM1, 1'b1, 1'b1,
                        8 + 2*s, 9 + 2*s, OPSIZE_W'(s));
            issue_instr();
        end

        test_id = 8'd3;
        repeat (2) @(negedge clk);
        load_fields(SRC_MEM1, SRC_MEM2, SRC_REG2, SRC_IMM, 1'b1, 1'b1, 3, 7, OPSIZE_32);
        fork
            issue_instr();
            begin
                @(negedge clk);
                fwd_stall = 1'b1;
                repeat (12) begin
                    @(negedge clk);
                    if (!stall || valid_out) begin
                        tb_errors++;
                        $display("Under fwd_stall stall went low or valid_out appeared");
                    end
                end
                fwd_stall = 1'b0;
            end
        join

        // Queue drained first, so at most k stores are outstanding before push k.
        test_id = 8'd4;
        repeat (4) @(negedge clk);
        for (int k = 0; k < WBQ_DEPTH; k++) begin
            if (wbaq_isfull) begin
                tb_errors++;
                $display("wbaq_isfull high with only %0d stores outstanding", k);
            end
            push_store(20 + k, {next_rand(), next_rand()});
        end
        load_fields(SRC_MEM1, SRC_MEM2, SRC_ZERO, SRC_REG3, 1'b1, 1'b1, 20, 21, OPSIZE_64);
        issue_instr();
        load_fields(SRC_MEM2, SRC_MEM1, SRC_SEG2, SRC_EIP, 1'b1, 1'b1, 22, 23, OPSIZE_64);
        issue_instr();

        test_id = 8'd5;
        for (int n = 0; n < RAND_INSTRS; n++) begin
            r = next_rand();
            if (r[20]) begin
                push_store(int'(r[30:24]), {next_rand(), next_rand()});
            end
            r = next_rand();
            q = next_rand();
            load_fields(r[3:0], r[7:4], r[11:8], r[15:12], r[16], r[17],
                        int'(q[22:16]), int'(q[30:24]), r[19:18]);
            issue_instr();
        end

        repeat (3) @(negedge clk);
        end_check = 1'b1;
        @(negedge clk);
        end_check = 1'b0;
        $display("Error counts: %0d mismatches, %0d protocol, %0d testbench",
                 mismatches, protocol_errors, tb_errors);
        if (mismatches + protocol_errors + tb_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- verif/mem_checker.sv
module mem_checker (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         exp_push,
    input  logic                         end_check,
    input  logic [7:0]                   test_id,
    input  logic [4*mem_pkg::SEL_W-1:0]  sels,
    input  logic [4*mem_pkg::DATA_W-1:0] regs,
    input  logic [4*mem_pkg::SEG_W-1:0]  segs,
    input  logic [mem_pkg::DATA_W-1:0]   imm,
    input  logic [mem_pkg::ADDR_W-1:0]   eip_in,
    input  logic [mem_pkg::OPSIZE_W-1:0] opsize_in,
    input  logic                         mem1_rd,
    input  logic                         mem2_rd,
    input  logic [mem_pkg::DATA_W-1:0]   mem1_word,
    input  logic [mem_pkg::DATA_W-1:0]   mem2_word,
    input  logic                         valid_out,
    input  logic [4*mem_pkg::DATA_W-1:0] ops,
    input  logic [mem_pkg::ADDR_W-1:0]   eip_out,
    input  logic [mem_pkg::OPSIZE_W-1:0] opsize_out,
    output int                           mismatches,
    output int                           protocol_errors
);

    import mem_pkg::*;

    typedef struct packed {
        logic [7:0]             test_id;
        logic [3:0][DATA_W-1:0] ops;
        logic [ADDR_W-1:0]      eip;
        logic [OPSIZE_W-1:0]    opsize;
    } expect_t;

    expect_t pending [$];

    function automatic string test_name(input logic [7:0] id);
        case (id)
            8'd1:    return "routing";
            8'd2:    return "store_then_load";
            8'd3:    return "fwd_stall";
            8'd4:    return "queue_burst";
            default: return "random";
        endcase
    endfunction

    // Low 8, 16, 32 or 64 bits kept.
    function automatic logic [DATA_W-1:0] keep_bits(input logic [OPSIZE_W-1:0] size);
        return ~({DATA_W{1'b1}} << (8 << size));
    endfunction

    ////////////////////
    // Reference model.
    ////////////////////

    function automatic logic [DATA_W-1:0] ref_operand(input logic [SEL_W-1:0] sel);
        logic [DATA_W-1:0] mem1_exp;
        logic [DATA_W-1:0] mem2_exp;
        mem1_exp = mem1_rd ? (mem1_word & keep_bits(opsize_in)) : '0;
        mem2_exp = mem2_rd ? (mem2_word & keep_bits(opsize_in)) : '0;
        if (sel <= SRC_REG4) begin
            return regs[int'(sel) * DATA_W +: DATA_W];
        end
        if (sel <= SRC_SEG4) begin
            return DATA_W'(segs[int'(sel - SRC_SEG1) * SEG_W +: SEG_W]);
        end
        case (sel)
            SRC_MEM1: return mem1_exp;
            SRC_MEM2: return mem2_exp;
            SRC_IMM:  return imm;
            SRC_EIP:  return DATA_W'(eip_in);
            default:  return '0;
        endcase
    endfunction

    task automatic compare(input logic [7:0] id, input string what,
                           input logic [DATA_W-1:0] expected,
                           input logic [DATA_W-1:0] actual);
        if (actual !== expected) begin
            mismatches++;
            $display("MISMATCH %s %s: expected %h, actual %h",
                     test_name(id), what, expected, actual);
        end
    endtask

    always @(posedge clk) begin
        expect_t item;
        if (!rst_n) begin
            mismatches      = 0;
            protocol_errors = 0;
            pending.delete();
        end else begin
            if (valid_out) begin
                if (pending.size() == 0) begin
                    protocol_errors++;
                    $display("valid_out seen with no instruction pending");
                end else begin
                    item = pending.pop_front();
                    for (int i = 0; i < 4; i++) begin
                        compare(item.test_id, $sformatf("op%0d", i + 1), item.ops[i],
                                ops[i*DATA_W +: DATA_W]);
                    end
                    compare(item.test_id, "eip", DATA_W'(item.eip), DATA_W'(eip_out));
                    compare(item.test_id, "opsize", DATA_W'(item.opsize), DATA_W'(opsize_out));
                end
            end
            // Inputs are held until acceptance, so the first cycle is enough.
            if (exp_push) begin
                item.test_id = test_id;
                for (int i = 0; i < 4; i++) begin
                    item.ops[i] = ref_operand(sels[i*SEL_W +: SEL_W]);
                end
                item.eip    = eip_in;
                item.opsize = opsize_in;
                pending.push_back(item);
            end
            if (end_check && pending.size() != 0) begin
                protocol_errors += pending.size();
                $display("%0d instruction(s) ended without a valid_out", pending.size());
                pending.delete();
            end
        end
    end

endmodule

//--- src/mem_stage.sv
module mem_stage (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         valid_in,
    input  logic                         fwd_stall,
    input  logic                         mem1_rd,
    input  logic                         mem2_rd,
    input  logic [mem_pkg::ADDR_W-1:0]   mem_addr1,
    input  logic [mem_pkg::ADDR_W-1:0]   mem_addr2,
    input  logic [mem_pkg::OPSIZE_W-1:0] opsize_in,
    input  logic [mem_pkg::DATA_W-1:0]   reg1,
    input  logic [mem_pkg::DATA_W-1:0]   reg2,
    input  logic [mem_pkg::DATA_W-1:0]   reg3,
    input  logic [mem_pkg::DATA_W-1:0]   reg4,
    input  logic [mem_pkg::SEG_W-1:0]    seg1,
    input  logic [mem_pkg::SEG_W-1:0]    seg2,
    input  logic [mem_pkg::SEG_W-1:0]    seg3,
    input  logic [mem_pkg::SEG_W-1:0]    seg4,
    input  logic [mem_pkg::DATA_W-1:0]   imm,
    input  logic [mem_pkg::ADDR_W-1:0]   eip_in,
    input  logic [mem_pkg::SEL_W-1:0]    op1_sel,
    input  logic [mem_pkg::SEL_W-1:0]    op2_sel,
    input  logic [mem_pkg::SEL_W-1:0]    op3_sel,
    input  logic [mem_pkg::SEL_W-1:0]    op4_sel,
    input  logic                         wb_valid,
    input  logic [mem_pkg::ADDR_W-1:0]   wb_memaddr,
    input  logic [mem_pkg::DATA_W-1:0]   wb_memdata,
    output logic                         wbaq_isfull,
    output logic                         stall,
    output logic                         valid_out,
    output logic [mem_pkg::DATA_W-1:0]   op1_val,
    output logic [mem_pkg::DATA_W-1:0]   op2_val,
    output logic [mem_pkg::DATA_W-1:0]   op3_val,
    output logic [mem_pkg::DATA_W-1:0]   op4_val,
    output logic [mem_pkg::ADDR_W-1:0]   eip_out,
    output logic [mem_pkg::OPSIZE_W-1:0] opsize_out
);

    import mem_pkg::*;

    logic              ld_req;
    logic              ld_gnt;
    logic [ADDR_W-1:0] ld_addr;
    logic              wq_req;
    logic              wq_gnt;
    logic [ADDR_W-1:0] wq_addr;
    logic [DATA_W-1:0] wq_data;
    logic              ram_en;
    logic              ram_we;
    logic [RAM_AW-1:0] ram_addr;
    logic [DATA_W-1:0] ram_wdata;
    logic [DATA_W-1:0] ram_rdata;
    logic [DATA_W-1:0] mem1_data;
    logic [DATA_W-1:0] mem2_data;
    logic              done;

    operand_loader operand_loader_inst (
        .clk(clk), .rst_n(rst_n), .valid_in(valid_in), .fwd_stall(fwd_stall),
        .mem1_rd(mem1_rd), .mem2_rd(mem2_rd), .mem_addr1(mem_addr1), .mem_addr2(mem_addr2),
        .opsize_in(opsize_in), .ld_req(ld_req), .ld_addr(ld_addr), .ld_gnt(ld_gnt),
        .ram_rdata(ram_rdata), .mem1_data(mem1_data), .mem2_data(mem2_data),
        .done(done), .stall(stall), .valid_out(valid_out)
    );

    wb_queue wb_queue_inst (
        .clk(clk), .rst_n(rst_n), .wb_valid(wb_valid), .wb_memaddr(wb_memaddr),
        .wb_memdata(wb_memdata), .wbaq_isfull(wbaq_isfull), .wq_req(wq_req),
        .wq_addr(wq_addr), .wq_data(wq_data), .wq_gnt(wq_gnt)
    );

    mem_arbiter mem_arbiter_inst (
        .clk(clk), .rst_n(rst_n), .wq_req(wq_req), .wq_addr(wq_addr), .wq_data(wq_data),
        .ld_req(ld_req), .ld_addr(ld_addr), .wq_gnt(wq_gnt), .ld_gnt(ld_gnt),
        .ram_en(ram_en), .ram_we(ram_we), .ram_addr(ram_addr), .ram_wdata(ram_wdata)
    );

    data_ram data_ram_inst (
        .clk(clk), .en(ram_en), .we(ram_we), .addr(ram_addr),
        .wdata(ram_wdata), .rdata(ram_rdata)
    );

    opswap opswap_inst (
        .clk(clk), .rst_n(rst_n), .done(done),
        .reg1(reg1), .reg2(reg2), .reg3(reg3), .reg4(reg4),
        .seg1(seg1), .seg2(seg2), .seg3(seg3), .seg4(seg4),
        .imm(imm), .eip_in(eip_in), .opsize_in(opsize_in),
        .op1_sel(op1_sel), .op2_sel(op2_sel), .op3_sel(op3_sel), .op4_sel(op4_sel),
        .mem1_data(mem1_data), .mem2_data(mem2_data),
        .op1_val(op1_val), .op2_val(op2_val), .op3_val(op3_val), .op4_val(op4_val),
        .eip_out(eip_out), .opsize_out(opsize_out)
    );

endmodule

//--- src/opswap.sv
module opswap (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         done,
    input  logic [mem_pkg::DATA_W-1:0]   reg1,
    input  logic [mem_pkg::DATA_W-1:0]   reg2,
    input  logic [mem_pkg::DATA_W-1:0]   reg3,
    input  logic [mem_pkg::DATA_W-1:0]   reg4,
    input  logic [mem_pkg::SEG_W-1:0]    seg1,
    input  logic [mem_pkg::SEG_W-1:0]    seg2,
    input  logic [mem_pkg::SEG_W-1:0]    seg3,
    input  logic [mem_pkg::SEG_W-1:0]    seg4,
    input  logic [mem_pkg::DATA_W-1:0]   imm,
    input  logic [mem_pkg::ADDR_W-1:0]   eip_in,
    input  logic [mem_pkg::OPSIZE_W-1:0] opsize_in,
    input  logic [mem_pkg::SEL_W-1:0]    op1_sel,
    input  logic [mem_pkg::SEL_W-1:0]    op2_sel,
    input  logic [mem_pkg::SEL_W-1:0]    op3_sel,
    input  logic [mem_pkg::SEL_W-1:0]    op4_sel,
    input  logic [mem_pkg::DATA_W-1:0]   mem1_data,
    input  logic [mem_pkg::DATA_W-1:0]   mem2_data,
    output logic [mem_pkg::DATA_W-1:0]   op1_val,
    output logic [mem_pkg::DATA_W-1:0]   op2_val,
    output logic [mem_pkg::DATA_W-1:0]   op3_val,
    output logic [mem_pkg::DATA_W-1:0]   op4_val,
    output logic [mem_pkg::ADDR_W-1:0]   eip_out,
    output logic [mem_pkg::OPSIZE_W-1:0] opsize_out
);

    import mem_pkg::*;

    // Source select for one operand.
    function automatic logic [DATA_W-1:0] pick(input logic [SEL_W-1:0] sel);
        case (sel)
            SRC_REG1: pick = reg1;
            SRC_REG2: pick = reg2;
            SRC_REG3: pick = reg3;
            SRC_REG4: pick = reg4;
            SRC_SEG1: pick = DATA_W'(seg1);
            SRC_SEG2: pick = DATA_W'(seg2);
            SRC_SEG3: pick = DATA_W'(seg3);
            SRC_SEG4: pick = DATA_W'(seg4);
            SRC_MEM1: pick = mem1_data;
            SRC_MEM2: pick = mem2_data;
            SRC_IMM:  pick = imm;
            SRC_EIP:  pick = DATA_W'(eip_in);
            SRC_ZERO: pick = '0;
            default:  pick = '0;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            op1_val    <= '0;
            op2_val    <= '0;
            op3_val    <= '0;
            op4_val    <= '0;
            eip_out    <= '0;
            opsize_out <= '0;
        end else if (done) begin
            op1_val    <= pick(op1_sel);
            op2_val    <= pick(op2_sel);
            op3_val    <= pick(op3_sel);
            op4_val    <= pick(op4_sel);
            eip_out    <= eip_in;
            opsize_out <= opsize_in;
        end
    end

endmodule

//--- src/operand_loader.sv
module operand_loader (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         valid_in,
    input  logic                         fwd_stall,
    input  logic                         mem1_rd,
    input  logic                         mem2_rd,
    input  logic [mem_pkg::ADDR_W-1:0]   mem_addr1,
    input  logic [mem_pkg::ADDR_W-1:0]   mem_addr2,
    input  logic [mem_pkg::OPSIZE_W-1:0] opsize_in,
    output logic                         ld_req,
    output logic [mem_pkg::ADDR_W-1:0]   ld_addr,
    input  logic                         ld_gnt,
    input  logic [mem_pkg::DATA_W-1:0]   ram_rdata,
    output logic [mem_pkg::DATA_W-1:0]   mem1_data,
    output logic [mem_pkg::DATA_W-1:0]   mem2_data,
    output logic                         done,
    output logic                         stall,
    output logic                         valid_out
);

    import mem_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_RD1,
        S_WT1,
        S_RD2,
        S_WT2,
        S_HOLD
    } state_t;

    state_t            state;
    state_t            state_nxt;
    logic [DATA_W-1:0] mem1_q;
    logic [DATA_W-1:0] mem2_q;

    // Zero-extend a loaded word to the operand size.
    function automatic logic [DATA_W-1:0] size_mask(
        input logic [DATA_W-1:0]   word,
        input logic [OPSIZE_W-1:0] size
    );
        size_mask = word;
        case (size)
            OPSIZE_8:  size_mask = DATA_W'(word[7:0]);
            OPSIZE_16: size_mask = DATA_W'(word[15:0]);
            OPSIZE_32: size_mask = DATA_W'(word[31:0]);
            OPSIZE_64: size_mask = word;
        endcase
    endfunction

    ////////////////////
    // Sequencer.
    ////////////////////

    always_comb begin
        state_nxt = state;
        done      = 1'b0;
        ld_req    = 1'b0;
        ld_addr   = mem_addr1;
        case (state)
            S_IDLE: begin
                if (valid_in && !fwd_stall) begin
                    if (mem1_rd) begin
                        state_nxt = S_RD1;
                    end else if (mem2_rd) begin
                        state_nxt = S_RD2;
                    end else begin
                        done = 1'b1;
                    end
                end
            end
            S_RD1: begin
                ld_req = 1'b1;
                if (ld_gnt) begin
                    state_nxt = S_WT1;
                end
            end
            S_WT1: begin
                state_nxt = mem2_rd ? S_RD2 : S_HOLD;
            end
            S_RD2: begin
                ld_req  = 1'b1;
                ld_addr = mem_addr2;
                if (ld_gnt) begin
                    state_nxt = S_WT2;
                end
            end
            S_WT2: begin
                state_nxt = S_HOLD;
            end
            S_HOLD: begin
                if (!fwd_stall) begin
                    done      = 1'b1;
                    state_nxt = S_IDLE;
                end
            end
            default: begin
                state_nxt = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            valid_out <= 1'b0;
        end else begin
            state     <= state_nxt;
            valid_out <= done;
        end
    end

    // Read data is valid in the cycle after the grant.
    always_ff @(posedge clk) begin
        if (state == S_WT1) begin
            mem1_q <= size_mask(ram_rdata, opsize_in);
        end
        if (state == S_WT2) begin
            mem2_q <= size_mask(ram_rdata, opsize_in);
        end
    end

    assign mem1_data = mem1_rd ? mem1_q : '0;
    assign mem2_data = mem2_rd ? mem2_q : '0;
    assign stall     = fwd_stall || (valid_in && !done);

    // Upstream holds its instruction until the stage lets go.
    assert property (@(posedge clk) disable iff (!rst_n) (valid_in && stall) |=> valid_in)
        else $error("operand_loader: valid_in dropped under stall");

endmodule

//--- src/wb_queue.sv
module wb_queue (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       wb_valid,
    input  logic [mem_pkg::ADDR_W-1:0] wb_memaddr,
    input  logic [mem_pkg::DATA_W-1:0] wb_memdata,
    output logic                       wbaq_isfull,
    output logic                       wq_req,
    output logic [mem_pkg::ADDR_W-1:0] wq_addr,
    output logic [mem_pkg::DATA_W-1:0] wq_data,
    input  logic                       wq_gnt
);

    import mem_pkg::*;

    logic [ADDR_W-1:0]    addr_q [WBQ_DEPTH];
    logic [DATA_W-1:0]    data_q [WBQ_DEPTH];
    logic [WBQ_PTR_W-1:0] wr_ptr;
    logic [WBQ_PTR_W-1:0] rd_ptr;
    logic [WBQ_PTR_W:0]   count;
    logic                 push;
    logic                 pop;

    assign push = wb_valid && !wbaq_isfull;
    assign pop  = wq_gnt;

    assign wbaq_isfull = (count == (WBQ_PTR_W + 1)'(WBQ_DEPTH));
    assign wq_req      = (count != '0);
    assign wq_addr     = addr_q[rd_ptr];
    assign wq_data     = data_q[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            addr_q[wr_ptr] <= wb_memaddr;
            data_q[wr_ptr] <= wb_memdata;
        end
    end

    // Pointers wrap at the last entry.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == WBQ_PTR_W'(WBQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == WBQ_PTR_W'(WBQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Writeback must respect the full flag.
    assert property (@(posedge clk) disable iff (!rst_n) wb_valid |-> !wbaq_isfull)
        else $error("wb_queue: store pushed while full");

endmodule

//--- src/mem_arbiter.sv
module mem_arbiter (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       wq_req,
    input  logic [mem_pkg::ADDR_W-1:0] wq_addr,
    input  logic [mem_pkg::DATA_W-1:0] wq_data,
    input  logic                       ld_req,
    input  logic [mem_pkg::ADDR_W-1:0] ld_addr,
    output logic                       wq_gnt,
    output logic                       ld_gnt,
    output logic                       ram_en,
    output logic                       ram_we,
    output logic [mem_pkg::RAM_AW-1:0] ram_addr,
    output logic [mem_pkg::DATA_W-1:0] ram_wdata
);

    import mem_pkg::*;

    logic [$clog2(STARVE_LIMIT):0] ld_wait;

    // Stores win, so a load always sees every store queued ahead of it.
    assign wq_gnt = wq_req;
    assign ld_gnt = ld_req && !wq_req;

    assign ram_en    = wq_gnt || ld_gnt;
    assign ram_we    = wq_gnt;
    assign ram_addr  = wq_gnt ? wq_addr[WORD_LSB +: RAM_AW] : ld_addr[WORD_LSB +: RAM_AW];
    assign ram_wdata = wq_data;

    // Run length of denied load requests.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ld_wait <= '0;
        end else if (ld_req && !ld_gnt) begin
            ld_wait <= ld_wait + 1'b1;
        end else begin
            ld_wait <= '0;
        end
    end

    ////////////////////
    // Checks.
    ////////////////////

    // A denied load keeps its request and address.
    assert property (@(posedge clk) disable iff (!rst_n)
        (ld_req && !ld_gnt) |=> (ld_req && $stable(ld_addr)))
        else $error("mem_arbiter: load request dropped or moved before its grant");

    assert property (@(posedge clk) disable iff (!rst_n) ld_wait < STARVE_LIMIT)
        else $error("mem_arbiter: load starved for %0d cycles", ld_wait);

endmodule

//--- src/data_ram.sv
module data_ram (
    input  logic                       clk,
    input  logic                       en,
    input  logic                       we,
    input  logic [mem_pkg::RAM_AW-1:0] addr,
    input  logic [mem_pkg::DATA_W-1:0] wdata,
    output logic [mem_pkg::DATA_W-1:0] rdata
);

    import mem_pkg::*;

    logic [DATA_W-1:0] mem [RAM_DEPTH];

    // Single port. Read data lands one cycle after the access.
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

//--- src/mem_pkg.sv
package mem_pkg;

    ////////////////////
    // Widths and depths.
    ////////////////////

    localparam int DATA_W   = 64;
    localparam int ADDR_W   = 32;
    localparam int SEG_W    = 16;
    localparam int OPSIZE_W = 2;
    localparam int SEL_W    = 4;

    localparam int RAM_DEPTH = 256;
    localparam int RAM_AW    = $clog2(RAM_DEPTH);
    // Byte offset bits inside a word.
    localparam int WORD_LSB  = 3;

    localparam int WBQ_DEPTH = 4;
    localparam int WBQ_PTR_W = $clog2(WBQ_DEPTH);

    // Longest tolerated run of denied load requests.
    localparam int STARVE_LIMIT = 64;

    ////////////////////
    // Operand source codes.
    ////////////////////

    localparam logic [SEL_W-1:0] SRC_REG1 = 4'd0;
    localparam logic [SEL_W-1:0] SRC_REG2 = 4'd1;
    localparam logic [SEL_W-1:0] SRC_REG3 = 4'd2;
    localparam logic [SEL_W-1:0] SRC_REG4 = 4'd3;
    localparam logic [SEL_W-1:0] SRC_SEG1 = 4'd4;
    localparam logic [SEL_W-1:0] SRC_SEG2 = 4'd5;
    localparam logic [SEL_W-1:0] SRC_SEG3 = 4'd6;
    localparam logic [SEL_W-1:0] SRC_SEG4 = 4'd7;
    localparam logic [SEL_W-1:0] SRC_MEM1 = 4'd8;
    localparam logic [SEL_W-1:0] SRC_MEM2 = 4'd9;
    localparam logic [SEL_W-1:0] SRC_IMM  = 4'd10;
    localparam logic [SEL_W-1:0] SRC_EIP  = 4'd11;
    localparam logic [SEL_W-1:0] SRC_ZERO = 4'd15;

    // Memory operand sizes.
    localparam logic [OPSIZE_W-1:0] OPSIZE_8  = 2'd0;
    localparam logic [OPSIZE_W-1:0] OPSIZE_16 = 2'd1;
    localparam logic [OPSIZE_W-1:0] OPSIZE_32 = 2'd2;
    localparam logic [OPSIZE_W-1:0] OPSIZE_64 = 2'd3;

endpackage
